// ==== dispatch_decode.sv ====
// decode side of the dispatch stage: unit select, last active thread,
// dispatch word packing, input handshake and per-unit stall counters

`timescale 1ns/100ps

module dispatch_decode import dispatch_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           flush,
    input  logic           in_valid,
    input  uuid_t          in_uuid,
    input  tmask_t         in_tmask,
    input  op_t            in_op,
    input  ex_type_t       in_ex_type,
    input  logic           in_is_branch,
    input  pc_t            in_pc,
    input  reg_t           in_rd,
    input  lane_data_t     in_rs1_data,
    input  lane_data_t     in_rs2_data,
    input  logic           alu_buf_ready,
    input  logic           lsu_buf_ready,
    input  logic           sfu_buf_ready,
    input  logic           issue_ok,
    output logic           in_ready,
    output logic           accept,
    output logic           push_alu,
    output logic           push_lsu,
    output logic           push_sfu,
    output dispatch_word_t dispatch_word,
    output perf_t          perf_stalls_alu,
    output perf_t          perf_stalls_lsu,
    output perf_t          perf_stalls_sfu
);

    logic sel_ready;
    logic stall;
    tid_t last_tid;

    // readiness of the buffer this instruction goes to
    always_comb begin
        case (in_ex_type)
            EX_ALU:  sel_ready = alu_buf_ready;
            EX_LSU:  sel_ready = lsu_buf_ready;
            EX_SFU:  sel_ready = sfu_buf_ready;
            default: sel_ready = 1'b0;
        endcase
    end

    // highest set mask bit, later iterations win
    always_comb begin
        last_tid = '0;
        for (int i = 0; i < THREAD_CNT; i++) begin
            if (in_tmask[i]) begin
                last_tid = tid_t'(i);
            end
        end
    end

    assign in_ready = sel_ready && issue_ok && !flush;
    assign accept   = in_valid && in_ready;

    assign push_alu = accept && (in_ex_type == EX_ALU);
    assign push_lsu = accept && (in_ex_type == EX_LSU);
    assign push_sfu = accept && (in_ex_type == EX_SFU);

    assign dispatch_word = {in_uuid, in_tmask, in_op, in_is_branch, in_pc, in_rd,
                            in_rs1_data, in_rs2_data, last_tid};

    assign stall = in_valid && !in_ready;

    // stall cycles, counted against the waiting instruction's unit
    always_ff @(posedge clk) begin
        if (reset) begin
            perf_stalls_alu <= '0;
            perf_stalls_lsu <= '0;
            perf_stalls_sfu <= '0;
        end else if (stall) begin
            if (in_ex_type == EX_ALU) perf_stalls_alu <= perf_stalls_alu + 1'b1;
            if (in_ex_type == EX_LSU) perf_stalls_lsu <= perf_stalls_lsu + 1'b1;
            if (in_ex_type == EX_SFU) perf_stalls_sfu <= perf_stalls_sfu + 1'b1;
        end
    end

    // an offered instruction always has at least one active thread
    tmask_nonzero: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> (in_tmask != '0));

endmodule

// ==== dispatch_pkg.sv ====
// widths, typedefs and limits shared by the dispatch stage
// execution-type enum and dispatch-word layout

package dispatch_pkg;

    // warp and datapath geometry
    localparam int THREAD_CNT = 4;
    localparam int TID_W      = 2;
    localparam int XLEN       = 32;

    // at most this many instructions between dispatch and commit
    localparam int MAX_INFLIGHT = 7;
    localparam int INFLIGHT_W   = 3;

    localparam int PERF_W = 16;

    typedef logic [THREAD_CNT-1:0]      tmask_t;
    typedef logic [TID_W-1:0]           tid_t;
    typedef logic [7:0]                 uuid_t;
    typedef logic [3:0]                 op_t;
    typedef logic [31:0]                pc_t;
    typedef logic [4:0]                 reg_t;
    // one operand, thread 0 in the low XLEN bits
    typedef logic [THREAD_CNT*XLEN-1:0] lane_data_t;
    typedef logic [INFLIGHT_W-1:0]      inflight_t;
    typedef logic [PERF_W-1:0]          perf_t;

    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2
    } ex_type_t;

    // dispatch word, most significant field first:
    // uuid, tmask, op, is_branch, pc, rd, rs1_data, rs2_data, last_tid
    localparam int DISPATCH_W = $bits(uuid_t)
                              + $bits(tmask_t)
                              + $bits(op_t)
                              + 1
                              + $bits(pc_t)
                              + $bits(reg_t)
                              + $bits(lane_data_t)
                              + $bits(lane_data_t)
                              + $bits(tid_t);

    typedef logic [DISPATCH_W-1:0] dispatch_word_t;

endpackage

// ==== dispatch_top.f ====
+incdir+.
dispatch_pkg.sv
dispatch_decode.sv
execution_staller.sv
fu_buffer.sv
dispatch_top.sv
dispatch_top_tb.sv

// ==== dispatch_top.sv ====
// dispatch stage top level
// decode, in-flight staller and one queue per functional unit

`timescale 1ns/100ps

module dispatch_top import dispatch_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           flush,
    input  logic           commit,
    input  logic           in_valid,
    output logic           in_ready,
    input  uuid_t          in_uuid,
    input  tmask_t         in_tmask,
    input  op_t            in_op,
    input  ex_type_t       in_ex_type,
    input  logic           in_is_branch,
    input  pc_t            in_pc,
    input  reg_t           in_rd,
    input  lane_data_t     in_rs1_data,
    input  lane_data_t     in_rs2_data,
    output logic           alu_valid,
    input  logic           alu_ready,
    output dispatch_word_t alu_data,
    output logic           lsu_valid,
    input  logic           lsu_ready,
    output dispatch_word_t lsu_data,
    output logic           sfu_valid,
    input  logic           sfu_ready,
    output dispatch_word_t sfu_data,
    output perf_t          perf_stalls_alu,
    output perf_t          perf_stalls_lsu,
    output perf_t          perf_stalls_sfu
);

    logic           accept;
    logic           issue_ok;
    logic           push_alu;
    logic           push_lsu;
    logic           push_sfu;
    logic           alu_buf_ready;
    logic           lsu_buf_ready;
    logic           sfu_buf_ready;
    dispatch_word_t dispatch_word;

    dispatch_decode dispatch_decode_inst (
        .clk             (clk),
        .reset           (reset),
        .flush           (flush),
        .in_valid        (in_valid),
        .in_uuid         (in_uuid),
        .in_tmask        (in_tmask),
        .in_op           (in_op),
        .in_ex_type      (in_ex_type),
        .in_is_branch    (in_is_branch),
        .in_pc           (in_pc),
        .in_rd           (in_rd),
        .in_rs1_data     (in_rs1_data),
        .in_rs2_data     (in_rs2_data),
        .alu_buf_ready   (alu_buf_ready),
        .lsu_buf_ready   (lsu_buf_ready),
        .sfu_buf_ready   (sfu_buf_ready),
        .issue_ok        (issue_ok),
        .in_ready        (in_ready),
        .accept          (accept),
        .push_alu        (push_alu),
        .push_lsu        (push_lsu),
        .push_sfu        (push_sfu),
        .dispatch_word   (dispatch_word),
        .perf_stalls_alu (perf_stalls_alu),
        .perf_stalls_lsu (perf_stalls_lsu),
        .perf_stalls_sfu (perf_stalls_sfu)
    );

    execution_staller execution_staller_inst (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .accept       (accept),
        .in_is_branch (in_is_branch),
        .commit       (commit),
        .issue_ok     (issue_ok)
    );

    fu_buffer alu_buffer (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (push_alu),
        .in_ready  (alu_buf_ready),
        .in_data   (dispatch_word),
        .out_valid (alu_valid),
        .out_ready (alu_ready),
        .out_data  (alu_data)
    );

    fu_buffer lsu_buffer (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (push_lsu),
        .in_ready  (lsu_buf_ready),
        .in_data   (dispatch_word),
        .out_valid (lsu_valid),
        .out_ready (lsu_ready),
        .out_data  (lsu_data)
    );

    fu_buffer sfu_buffer (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .in_valid  (push_sfu),
        .in_ready  (sfu_buf_ready),
        .in_data   (dispatch_word),
        .out_valid (sfu_valid),
        .out_ready (sfu_ready),
        .out_data  (sfu_data)
    );

endmodule

// ==== tb_checks.svh ====
// testbench helpers: LFSR step, expected dispatch word,
// compare tasks that stop the run on the first mismatch

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// 16-bit Fibonacci LFSR step with taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

// highest active thread of a mask
function automatic tid_t last_tid_of(input tmask_t tmask);
    casez (tmask)
        4'b1???: last_tid_of = tid_t'(3);
        4'b01??: last_tid_of = tid_t'(2);
        4'b001?: last_tid_of = tid_t'(1);
        default: last_tid_of = tid_t'(0);
    endcase
endfunction

// expected word in the package's field order
function automatic dispatch_word_t pack_dispatch(
    input uuid_t      uuid,
    input tmask_t     tmask,
    input op_t        op,
    input logic       is_branch,
    input pc_t        pc,
    input reg_t       rd,
    input lane_data_t rs1_data,
    input lane_data_t rs2_data
);
    pack_dispatch = {uuid, tmask, op, is_branch, pc, rd, rs1_data, rs2_data,
                     last_tid_of(tmask)};
endfunction

task automatic report_fail(input string name, input string got, input string exp);
    $display("FAILED at %0t: %s got %s expected %s", $time, name, got, exp);
    $display("RESULT: FAIL");
    $fatal(1);
endtask

task automatic compare_word(input string name, input dispatch_word_t got,
                            input dispatch_word_t exp);
    if (got !== exp) begin
        report_fail(name, $sformatf("%h", got), $sformatf("%h", exp));
    end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        report_fail(name, $sformatf("%b", got), $sformatf("%b", exp));
    end
endtask

task automatic compare_perf(input string name, input perf_t got, input perf_t exp);
    if (got !== exp) begin
        report_fail(name, $sformatf("%0d", got), $sformatf("%0d", exp));
    end
endtask

`endif

// ==== dispatch_top_tb.sv ====
// testbench for the dispatch stage: clock, reset, watchdog,
// output scoreboard and directed tests

`timescale 1ns/100ps

module dispatch_top_tb import dispatch_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    // six tests of well under 100 cycles each plus a wide margin
    localparam int CYCLE_LIMIT = 2000;

    logic           clk = 1'b0;
    logic           reset;
    logic           flush;
    logic           commit;
    logic           in_valid;
    logic           in_ready;
    uuid_t          in_uuid;
    tmask_t         in_tmask;
    op_t            in_op;
    ex_type_t       in_ex_type;
    logic           in_is_branch;
    pc_t            in_pc;
    reg_t           in_rd;
    lane_data_t     in_rs1_data;
    lane_data_t     in_rs2_data;
    logic           alu_valid;
    logic           alu_ready;
    dispatch_word_t alu_data;
    logic           lsu_valid;
    logic           lsu_ready;
    dispatch_word_t lsu_data;
    logic           sfu_valid;
    logic           sfu_ready;
    dispatch_word_t sfu_data;
    perf_t          perf_stalls_alu;
    perf_t          perf_stalls_lsu;
    perf_t          perf_stalls_sfu;

    `include "tb_checks.svh"

    logic [15:0]    lfsr_state = 16'd27;
    uuid_t          next_uuid = '0;
    dispatch_word_t cur_word;
    int             inflight = 0;
    int             cycle_count = 0;
    perf_t          exp_stalls_alu = '0;
    perf_t          exp_stalls_lsu = '0;
    perf_t          exp_stalls_sfu = '0;

    // expected words per unit; the monitor only advances the seen counts
    dispatch_word_t alu_expect[$];
    dispatch_word_t lsu_expect[$];
    dispatch_word_t sfu_expect[$];
    int             alu_seen = 0;
    int             lsu_seen = 0;
    int             sfu_seen = 0;
    int             alu_dropped = 0;
    int             lsu_dropped = 0;
    int             sfu_dropped = 0;

    dispatch_top dispatch_top_inst (.*);

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic stop_with_error(input string why);
        $display("%s at %0t", why, $time);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == CYCLE_LIMIT) begin
            stop_with_error("timeout, the tests did not finish within the cycle limit");
        end
    end

    // width bits from the LFSR with one step per bit taken
    function automatic logic [127:0] random_bits(input int width);
        logic [127:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[126:0], lfsr_state[0]};
        end
        return value;
    endfunction

    task automatic check_output(input string name, input dispatch_word_t got, input int index,
                                input int sent, input dispatch_word_t exp);
        if (index >= sent) begin
            stop_with_error({name, " showed an item that was never dispatched to it"});
        end else begin
            compare_word(name, got, exp);
        end
    endtask

    // every transfer to a unit must be the next word sent to that unit
    always @(posedge clk) begin
        if (!reset && alu_valid && alu_ready) begin
            check_output("alu_data", alu_data, alu_seen + alu_dropped, alu_expect.size(),
                         alu_expect[alu_seen + alu_dropped]);
            alu_seen = alu_seen + 1;
        end
        if (!reset && lsu_valid && lsu_ready) begin
            check_output("lsu_data", lsu_data, lsu_seen + lsu_dropped, lsu_expect.size(),
                         lsu_expect[lsu_seen + lsu_dropped]);
            lsu_seen = lsu_seen + 1;
        end
        if (!reset && sfu_valid && sfu_ready) begin
            check_output("sfu_data", sfu_data, sfu_seen + sfu_dropped, sfu_expect.size(),
                         sfu_expect[sfu_seen + sfu_dropped]);
            sfu_seen = sfu_seen + 1;
        end
    end

    // new instruction with random payload offered at a falling edge
    task automatic make_instr(input ex_type_t ex, input logic branch);
        tmask_t mask;
        mask = '0;
        while (mask == '0) begin
            mask = tmask_t'(random_bits(THREAD_CNT));
        end
        in_uuid      = next_uuid;
        next_uuid    = next_uuid + 1'b1;
        in_tmask     = mask;
        in_op        = op_t'(random_bits(4));
        in_ex_type   = ex;
        in_is_branch = branch;
        in_pc        = pc_t'(random_bits(32));
        in_rd        = reg_t'(random_bits(5));
        in_rs1_data  = random_bits(128);
        in_rs2_data  = random_bits(128);
        cur_word     = pack_dispatch(in_uuid, in_tmask, in_op, in_is_branch, in_pc, in_rd,
                                     in_rs1_data, in_rs2_data);
        in_valid     = 1'b1;
    endtask

    task automatic count_stall();
        case (in_ex_type)
            EX_ALU:  exp_stalls_alu = exp_stalls_alu + 1'b1;
            EX_LSU:  exp_stalls_lsu = exp_stalls_lsu + 1'b1;
            default: exp_stalls_sfu = exp_stalls_sfu + 1'b1;
        endcase
    endtask

    task automatic record_accept();
        case (in_ex_type)
            EX_ALU:  alu_expect.push_back(cur_word);
            EX_LSU:  lsu_expect.push_back(cur_word);
            default: sfu_expect.push_back(cur_word);
        endcase
        inflight = inflight + 1;
        in_valid = 1'b0;
    endtask

    // instruction that must go through in its first cycle
    task automatic send_now(input ex_type_t ex, input logic branch);
        make_instr(ex, branch);
        #1;
        compare_bit("in_ready", in_ready, 1'b1);
        @(negedge clk);
        record_accept();
    endtask

    task automatic wait_accept();
        #1;
        while (!in_ready) begin
            count_stall();
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        record_accept();
    endtask

    // offered instruction has to stay blocked for these cycles
    task automatic hold_stalled(input int cycles);
        repeat (cycles) begin
            #1;
            compare_bit("in_ready", in_ready, 1'b0);
            count_stall();
            @(negedge clk);
        end
    endtask

    task automatic commit_pulse();
        commit = 1'b1;
        @(negedge clk);
        commit   = 1'b0;
        inflight = inflight - 1;
    endtask

    task automatic commit_while_stalled();
        commit = 1'b1;
        hold_stalled(1);
        commit   = 1'b0;
        inflight = inflight - 1;
    endtask

    task automatic commit_all();
        while (inflight > 0) begin
            commit_pulse();
        end
    endtask

    function automatic logic outputs_pending();
        return (alu_seen + alu_dropped != alu_expect.size())
            || (lsu_seen + lsu_dropped != lsu_expect.size())
            || (sfu_seen + sfu_dropped != sfu_expect.size());
    endfunction

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (outputs_pending() && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (outputs_pending()) begin
            stop_with_error("dispatched instructions did not all reach their unit outputs");
        end else begin
            compare_bit("alu_valid", alu_valid, 1'b0);
            compare_bit("lsu_valid", lsu_valid, 1'b0);
            compare_bit("sfu_valid", sfu_valid, 1'b0);
        end
    endtask

    task automatic test_routing();
        ex_type_t ex;
        repeat (3) begin
            for (int t = 0; t < 3; t++) begin
                ex = ex_type_t'(t);
                send_now(ex, 1'b0);
                // one cycle latency and only the target unit shows the word
                compare_bit("alu_valid", alu_valid, ex == EX_ALU);
                compare_bit("lsu_valid", lsu_valid, ex == EX_LSU);
                compare_bit("sfu_valid", sfu_valid, ex == EX_SFU);
                commit_pulse();
            end
        end
        wait_drained();
    endtask

    task automatic test_back_pressure();
        alu_ready = 1'b0;
        send_now(EX_ALU, 1'b0);
        send_now(EX_ALU, 1'b0);
        // lsu path stays open with the alu queue full
        send_now(EX_LSU, 1'b0);
        make_instr(EX_ALU, 1'b0);
        hold_stalled(3);
        alu_ready = 1'b1;
        wait_accept();
        wait_drained();
        commit_all();
    endtask

    task automatic test_branch_isolation();
        send_now(EX_LSU, 1'b0);
        make_instr(EX_ALU, 1'b1);
        hold_stalled(3);
        commit_while_stalled();
        wait_accept();
        // nothing may follow until the branch commits
        make_instr(EX_SFU, 1'b0);
        hold_stalled(3);
        commit_while_stalled();
        wait_accept();
        wait_drained();
        commit_all();
    endtask

    task automatic test_inflight_limit();
        repeat (MAX_INFLIGHT) begin
            send_now(EX_ALU, 1'b0);
        end
        make_instr(EX_SFU, 1'b0);
        hold_stalled(3);
        commit_while_stalled();
        wait_accept();
        wait_drained();
        commit_all();
    endtask

    task automatic test_flush();
        alu_ready = 1'b0;
        lsu_ready = 1'b0;
        send_now(EX_ALU, 1'b0);
        send_now(EX_ALU, 1'b0);
        send_now(EX_LSU, 1'b0);
        compare_bit("alu_valid", alu_valid, 1'b1);
        compare_bit("lsu_valid", lsu_valid, 1'b1);
        flush = 1'b1;
        #1;
        compare_bit("in_ready", in_ready, 1'b0);
        @(negedge clk);
        flush = 1'b0;
        compare_bit("alu_valid", alu_valid, 1'b0);
        compare_bit("lsu_valid", lsu_valid, 1'b0);
        compare_bit("sfu_valid", sfu_valid, 1'b0);
        alu_dropped = alu_expect.size() - alu_seen;
        lsu_dropped = lsu_expect.size() - lsu_seen;
        sfu_dropped = sfu_expect.size() - sfu_seen;
        inflight    = 0;
        // both alu entries free again and no commits owed
        send_now(EX_ALU, 1'b0);
        send_now(EX_ALU, 1'b0);
        alu_ready = 1'b1;
        lsu_ready = 1'b1;
        send_now(EX_LSU, 1'b0);
        // flushed instructions no longer count toward the in-flight limit
        repeat (MAX_INFLIGHT - 3) begin
            send_now(EX_SFU, 1'b0);
        end
        wait_drained();
        commit_all();
    endtask

    task automatic test_stall_counters();
        sfu_ready = 1'b0;
        send_now(EX_SFU, 1'b0);
        send_now(EX_SFU, 1'b0);
        make_instr(EX_SFU, 1'b0);
        hold_stalled(4);
        sfu_ready = 1'b1;
        wait_accept();
        lsu_ready = 1'b0;
        send_now(EX_LSU, 1'b0);
        send_now(EX_LSU, 1'b0);
        make_instr(EX_LSU, 1'b0);
        hold_stalled(2);
        lsu_ready = 1'b1;
        wait_accept();
        wait_drained();
        commit_all();
        compare_perf("perf_stalls_alu", perf_stalls_alu, exp_stalls_alu);
        compare_perf("perf_stalls_lsu", perf_stalls_lsu, exp_stalls_lsu);
        compare_perf("perf_stalls_sfu", perf_stalls_sfu, exp_stalls_sfu);
    endtask

    initial begin
        reset        = 1'b1;
        flush        = 1'b0;
        commit       = 1'b0;
        in_valid     = 1'b0;
        in_uuid      = '0;
        in_tmask     = 4'b0001;
        in_op        = '0;
        in_ex_type   = EX_ALU;
        in_is_branch = 1'b0;
        in_pc        = '0;
        in_rd        = '0;
        in_rs1_data  = '0;
        in_rs2_data  = '0;
        alu_ready    = 1'b1;
        lsu_ready    = 1'b1;
        sfu_ready    = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        compare_bit("alu_valid", alu_valid, 1'b0);
        compare_bit("lsu_valid", lsu_valid, 1'b0);
        compare_bit("sfu_valid", sfu_valid, 1'b0);
        compare_bit("in_ready", in_ready, 1'b1);
        compare_perf("perf_stalls_alu", perf_stalls_alu, '0);
        compare_perf("perf_stalls_lsu", perf_stalls_lsu, '0);
        compare_perf("perf_stalls_sfu", perf_stalls_sfu, '0);
        test_routing();
        test_back_pressure();
        test_branch_isolation();
        test_inflight_limit();
        test_flush();
        test_stall_counters();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== execution_staller.sv ====
// in-flight tracking between dispatch and commit
// blocks issue at the in-flight limit and around branches

`timescale 1ns/100ps

module execution_staller import dispatch_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic accept,
    input  logic in_is_branch,
    input  logic commit,
    output logic issue_ok
);

    inflight_t count_r;
    inflight_t count_next;
    logic      branch_pending_r;
    logic      at_limit;
    logic      branch_waits;

    always_comb begin
        count_next = count_r;
        case ({accept, commit})
            2'b10:   count_next = count_r + 1'b1;
            2'b01:   count_next = count_r - 1'b1;
            default: count_next = count_r;
        endcase
    end

    assign at_limit = (count_r == inflight_t'(MAX_INFLIGHT));

    // a branch only goes out into an empty pipeline
    assign branch_waits = in_is_branch && (count_r != '0);

    assign issue_ok = !at_limit && !branch_waits && !branch_pending_r;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            count_r <= '0;
        end else begin
            count_r <= count_next;
        end
    end

    // held from branch acceptance until the pipeline drains again
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            branch_pending_r <= 1'b0;
        end else if (accept && in_is_branch) begin
            branch_pending_r <= 1'b1;
        end else if (count_next == '0) begin
            branch_pending_r <= 1'b0;
        end
    end

    // commits only come back for instructions that were dispatched
    commit_has_owner: assert property (@(posedge clk) disable iff (reset)
        commit && !flush |-> (count_r != '0));

    // decode never transfers past a block raised here
    accept_only_when_ok: assert property (@(posedge clk) disable iff (reset)
        accept |-> issue_ok);

endmodule

// ==== fu_buffer.sv ====
// two-entry elastic queue for one functional unit
// registered head plus skid register, cleared by flush

`timescale 1ns/100ps

module fu_buffer import dispatch_pkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  logic           flush,
    input  logic           in_valid,
    output logic           in_ready,
    input  dispatch_word_t in_data,
    output logic           out_valid,
    input  logic           out_ready,
    output dispatch_word_t out_data
);

    logic           skid_valid_r;
    dispatch_word_t skid_data_r;
    logic           push;
    logic           head_free;

    // full only when both head and skid hold an item
    assign in_ready = !skid_valid_r;
    assign push     = in_valid && in_ready;

    // head can take a new item this cycle
    assign head_free = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            out_valid    <= 1'b0;
            skid_valid_r <= 1'b0;
        end else if (head_free) begin
            // skid item is older than anything arriving now
            if (skid_valid_r) begin
                out_valid    <= 1'b1;
                skid_valid_r <= 1'b0;
            end else begin
                out_valid <= push;
            end
        end else if (push) begin
            skid_valid_r <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (head_free) begin
            if (skid_valid_r) begin
                out_data <= skid_data_r;
            end else if (push) begin
                out_data <= in_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!head_free && push) begin
            skid_data_r <= in_data;
        end
    end

    // held head stays put until the unit takes it
    head_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !flush |=> $stable(out_data));

endmodule

// ==== run.sh ====
#!/bin/sh
# build the dispatch stage testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module dispatch_top_tb \
    -Mdir obj_dir -f dispatch_top.f > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/Vdispatch_top_tb > sim.log 2>&1
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
